// ==== nx_arbiter.sv ====
// ############################
// Two-to-one merge of streams with last
// Data path is combinational
// A message holds the output until its last word
// ############################
`timescale 1ns/1ps

module nx_arbiter #(
    parameter int BUS_W = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [BUS_W-1:0] inbound_a_data,
    input  logic             inbound_a_last,
    input  logic             inbound_a_valid,
    output logic             inbound_a_ready,
    input  logic [BUS_W-1:0] inbound_b_data,
    input  logic             inbound_b_last,
    input  logic             inbound_b_valid,
    output logic             inbound_b_ready,
    output logic [BUS_W-1:0] outbound_data,
    output logic             outbound_last,
    output logic             outbound_valid,
    input  logic             outbound_ready
);

    // Set while a message is part way through
    logic lock_q;
    // Source of the most recent accepted word, high for B
    logic prev_b;
    logic sel_b;

    always_comb begin
        if (lock_q) begin
            // Stay on the source whose message is open
            sel_b = prev_b;
        end else if (!inbound_b_valid) begin
            sel_b = 1'b0;
        end else if (prev_b && inbound_a_valid) begin
            // B went last and A is waiting, so give A its turn
            sel_b = 1'b0;
        end else begin
            sel_b = 1'b1;
        end
    end

    assign outbound_data   = sel_b ? inbound_b_data : inbound_a_data;
    assign outbound_last   = sel_b ? inbound_b_last : inbound_a_last;
    assign outbound_valid  = sel_b ? inbound_b_valid : inbound_a_valid;
    assign inbound_a_ready = outbound_ready && !sel_b;
    assign inbound_b_ready = outbound_ready && sel_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lock_q <= 1'b0;
            prev_b <= 1'b0;
        end else if (outbound_valid && outbound_ready) begin
            lock_q <= !outbound_last;
            prev_b <= sel_b;
        end
    end

    // A source must keep an offered word in place until the merge takes it
    a_hold_a: assert property (@(posedge clk) disable iff (rst)
        inbound_a_valid && !inbound_a_ready |=> inbound_a_valid && $stable(inbound_a_data));

    a_hold_b: assert property (@(posedge clk) disable iff (rst)
        inbound_b_valid && !inbound_b_ready |=> inbound_b_valid && $stable(inbound_b_data));

endmodule

// ==== nx_decode.sv ====
// ############################
// Inbound ready is low for one cycle after reset
// Header words for other nodes pass straight to the bypass
// Write or add headers must be followed by one value word
// ############################
`timescale 1ns/1ps

module nx_decode #(
    parameter nx_pkg::nx_node_t NODE_ID = 4'd0
) (
    input  logic                clk,
    input  logic                rst,
    input  nx_pkg::nx_word_t    in_data,
    input  logic                in_last,
    input  logic                in_valid,
    output logic                in_ready,
    output nx_pkg::nx_word_t    byp_data,
    output logic                byp_last,
    output logic                byp_valid,
    input  logic                byp_ready,
    output nx_pkg::nx_opcode_e  cmd_op,
    output nx_pkg::nx_reg_idx_t cmd_reg,
    output nx_pkg::nx_word_t    cmd_value,
    output logic                cmd_valid,
    input  logic                cmd_ready
);
    import nx_pkg::*;

    dec_state_e  state;
    logic        live;
    logic        to_other;
    logic        in_fire;
    nx_opcode_e  hdr_op;
    nx_reg_idx_t hdr_reg;
    nx_opcode_e  op_q;
    nx_reg_idx_t reg_q;
    nx_word_t    val_q;

    // Header fields, only meaningful while in DEC_HEADER
    assign to_other = (in_data[HDR_NODE_LSB +: $bits(nx_node_t)] != NODE_ID);
    assign hdr_op   = nx_opcode_e'(in_data[HDR_OP_LSB +: $bits(nx_opcode_e)]);
    assign hdr_reg  = in_data[HDR_REG_LSB +: $bits(nx_reg_idx_t)];

    // The bypass always sees the inbound word, valid decides if it counts
    assign byp_data = in_data;
    assign byp_last = in_last;

    always_comb begin
        byp_valid = 1'b0;
        in_ready  = 1'b0;
        case (state)
            DEC_HEADER: begin
                // A foreign header moves only when the bypass can take it
                byp_valid = live && in_valid && to_other;
                in_ready  = live && (to_other ? byp_ready : 1'b1);
            end
            DEC_DATA: begin
                in_ready = 1'b1;
            end
            DEC_FORWARD: begin
                byp_valid = in_valid;
                in_ready  = byp_ready;
            end
            default: begin
                // DEC_ISSUE stalls the inbound stream until the command leaves
                in_ready = 1'b0;
            end
        endcase
    end

    assign in_fire   = in_valid && in_ready;
    assign cmd_valid = (state == DEC_ISSUE);
    assign cmd_op    = op_q;
    assign cmd_reg   = reg_q;
    assign cmd_value = val_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DEC_HEADER;
            live  <= 1'b0;
        end else begin
            live <= 1'b1;
            case (state)
                DEC_HEADER: begin
                    if (in_fire && to_other && !in_last) begin
                        state <= DEC_FORWARD;
                    end else if (in_fire && !to_other && hdr_op == OP_READ) begin
                        state <= DEC_ISSUE;
                    end else if (in_fire && !to_other && hdr_op != OP_RSVD) begin
                        state <= DEC_DATA;
                    end
                end
                DEC_DATA: begin
                    if (in_fire) begin
                        state <= DEC_ISSUE;
                    end
                end
                DEC_FORWARD: begin
                    if (in_fire && in_last) begin
                        state <= DEC_HEADER;
                    end
                end
                default: begin
                    if (cmd_ready) begin
                        state <= DEC_HEADER;
                    end
                end
            endcase
        end
    end

    // Command fields are gathered as their words are taken
    always_ff @(posedge clk) begin
        if (state == DEC_HEADER && in_fire && !to_other) begin
            op_q  <= hdr_op;
            reg_q <= hdr_reg;
        end
        if (state == DEC_DATA && in_fire) begin
            val_q <= in_data;
        end
    end

    // An offered command stays offered until execute takes it
    a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid);

    // No inbound word is taken while a command waits
    a_issue_stall: assert property (@(posedge clk) disable iff (rst)
        cmd_valid |-> !(in_valid && in_ready));

endmodule

// ==== nx_execute.sv ====
// ############################
// All sixteen registers clear on reset
// Adds wrap at 32 bits
// Response header has only opcode and register index set
// ############################
`timescale 1ns/1ps

module nx_execute (
    input  logic                clk,
    input  logic                rst,
    input  nx_pkg::nx_opcode_e  cmd_op,
    input  nx_pkg::nx_reg_idx_t cmd_reg,
    input  nx_pkg::nx_word_t    cmd_value,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output nx_pkg::nx_word_t    res_header,
    output nx_pkg::nx_word_t    res_value,
    output logic                res_valid,
    input  logic                res_ready
);
    import nx_pkg::*;

    nx_word_t    regs [NX_NUM_REGS];
    nx_word_t    cur;
    nx_word_t    sum;
    logic        cmd_fire;
    nx_opcode_e  res_op;
    nx_reg_idx_t res_reg;

    // A new command is taken only once the last result has gone
    assign cmd_ready = !res_valid;
    assign cmd_fire  = cmd_valid && cmd_ready;

    // Current register value and the wrapped sum for an add
    assign cur = regs[cmd_reg];
    assign sum = cur + cmd_value;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NX_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            res_valid <= 1'b0;
        end else begin
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
            if (cmd_fire) begin
                case (cmd_op)
                    OP_WRITE: regs[cmd_reg] <= cmd_value;
                    OP_ADD: begin
                        regs[cmd_reg] <= sum;
                        res_valid     <= 1'b1;
                    end
                    OP_READ: res_valid <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Returned value is the new sum for an add and the old value otherwise
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            res_op    <= cmd_op;
            res_reg   <= cmd_reg;
            res_value <= (cmd_op == OP_ADD) ? sum : cur;
        end
    end

    // Rebuild the request header from the captured fields
    always_comb begin
        res_header = '0;
        res_header[HDR_OP_LSB +: $bits(nx_opcode_e)]   = res_op;
        res_header[HDR_REG_LSB +: $bits(nx_reg_idx_t)] = res_reg;
    end

    // A waiting result keeps its valid and both words until taken
    a_res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_header) && $stable(res_value));

endmodule

// ==== nx_node.sv ====
// ############################
// One node of the message network
// BUS_W must stay at 32, the word width of the package
// Output order between bypass and responses is not fixed
// ############################
`timescale 1ns/1ps

module nx_node #(
    parameter nx_pkg::nx_node_t NODE_ID = 4'd1,
    parameter int               BUS_W   = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  nx_pkg::nx_word_t in_data,
    input  logic             in_last,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [BUS_W-1:0] out_data,
    output logic             out_last,
    output logic             out_valid,
    input  logic             out_ready
);
    import nx_pkg::*;

    // Messages for other nodes, toward arbiter input A
    nx_word_t    byp_data;
    logic        byp_last;
    logic        byp_valid;
    logic        byp_ready;

    // Local commands from decode to execute
    nx_opcode_e  cmd_op;
    nx_reg_idx_t cmd_reg;
    nx_word_t    cmd_value;
    logic        cmd_valid;
    logic        cmd_ready;

    // Results of read and add
    nx_word_t    res_header;
    nx_word_t    res_value;
    logic        res_valid;
    logic        res_ready;

    // Serialized responses, toward arbiter input B
    nx_word_t    rsp_data;
    logic        rsp_last;
    logic        rsp_valid;
    logic        rsp_ready;

    nx_decode #(.NODE_ID(NODE_ID)) dec0 (
        .clk, .rst,
        .in_data, .in_last, .in_valid, .in_ready,
        .byp_data, .byp_last, .byp_valid, .byp_ready,
        .cmd_op, .cmd_reg, .cmd_value, .cmd_valid, .cmd_ready
    );

    nx_execute exe0 (
        .clk, .rst,
        .cmd_op, .cmd_reg, .cmd_value, .cmd_valid, .cmd_ready,
        .res_header, .res_value, .res_valid, .res_ready
    );

    nx_result res0 (
        .clk, .rst,
        .res_header, .res_value, .res_valid, .res_ready,
        .rsp_data, .rsp_last, .rsp_valid, .rsp_ready
    );

    nx_arbiter #(.BUS_W(BUS_W)) arb0 (
        .clk, .rst,
        .inbound_a_data(byp_data), .inbound_a_last(byp_last),
        .inbound_a_valid(byp_valid), .inbound_a_ready(byp_ready),
        .inbound_b_data(rsp_data), .inbound_b_last(rsp_last),
        .inbound_b_valid(rsp_valid), .inbound_b_ready(rsp_ready),
        .outbound_data(out_data), .outbound_last(out_last),
        .outbound_valid(out_valid), .outbound_ready(out_ready)
    );

endmodule

// ==== nx_pkg.sv ====
// ############################
// Shared types and constants of the message node
// Header layout is fixed to a 32-bit word
// Bits outside the listed fields are carried but never read
// ############################

package nx_pkg;

    // One bus word, used for headers and for data alike
    typedef logic [31:0] nx_word_t;

    // Node number and register index as held in a header
    typedef logic [3:0] nx_node_t;
    typedef logic [3:0] nx_reg_idx_t;

    // Size of the local register file
    localparam int NX_NUM_REGS = 16;

    // Operations a local message may request
    typedef enum logic [1:0] {
        // Two words, header then the value to store
        OP_WRITE = 2'd0,
        // One word, answered with the register value
        OP_READ  = 2'd1,
        // Two words, accumulates and answers with the new value
        OP_ADD   = 2'd2,
        // One word, consumed and ignored
        OP_RSVD  = 2'd3
    } nx_opcode_e;

    // Lowest bit of each header field
    // Node number sits in bits 31 to 28
    localparam int HDR_NODE_LSB = 28;
    // Opcode sits in bits 27 to 26
    localparam int HDR_OP_LSB   = 26;
    // Register index sits in bits 23 to 20
    localparam int HDR_REG_LSB  = 20;

    // Decode FSM states
    typedef enum logic [1:0] {
        // Waiting for the first word of a message
        DEC_HEADER  = 2'd0,
        // Waiting for the value word of a write or add
        DEC_DATA    = 2'd1,
        // Streaming the rest of a message to the bypass
        DEC_FORWARD = 2'd2,
        // Offering the gathered command to execute
        DEC_ISSUE   = 2'd3
    } dec_state_e;

endpackage

// ==== nx_result.sv ====
// ############################
// One result is held at a time
// There is a bubble cycle between back to back responses
// ############################
`timescale 1ns/1ps

module nx_result (
    input  logic             clk,
    input  logic             rst,
    input  nx_pkg::nx_word_t res_header,
    input  nx_pkg::nx_word_t res_value,
    input  logic             res_valid,
    output logic             res_ready,
    output nx_pkg::nx_word_t rsp_data,
    output logic             rsp_last,
    output logic             rsp_valid,
    input  logic             rsp_ready
);
    import nx_pkg::*;

    logic     busy;
    logic     word_sel;
    nx_word_t hdr_q;
    nx_word_t val_q;

    // Only an idle stage can accept a new result
    assign res_ready = !busy;

    // Header goes first, the value word closes the message
    assign rsp_valid = busy;
    assign rsp_data  = word_sel ? val_q : hdr_q;
    assign rsp_last  = word_sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            word_sel <= 1'b0;
        end else if (res_valid && res_ready) begin
            busy     <= 1'b1;
            word_sel <= 1'b0;
        end else if (rsp_valid && rsp_ready) begin
            // Step to the value word, or finish after it
            word_sel <= 1'b1;
            busy     <= !word_sel;
        end
    end

    // Both words are held until the message has been sent
    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            hdr_q <= res_header;
            val_q <= res_value;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the node testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_nx_node \
    --Mdir obj_dir \
    -o tb_nx_node_sim

./obj_dir/tb_nx_node_sim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

// ==== tb_clock.sv ====
// ############################
// Testbench clock and reset
// Clock period is 10 ns
// Reset is high from time zero for 5 rising edges
// ############################
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset drops 1 ns after an edge, in step with the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== tb_nx_node.sv ====
// ############################
// Directed tests of one node with id 5
// Responses are matched on a cleared node field
// Forwarded traffic never uses node 0 or node 5
// ############################
`timescale 1ns/1ps

module tb_nx_node;
    import nx_pkg::*;

    localparam nx_node_t NODE_ID     = 4'd5;
    localparam int       SEED        = 88;
    localparam int       DRIVE_DELAY = 1;
    localparam int       NUM_TESTS   = 5;
    localparam int       DRAIN_LIMIT = 400;

    logic        clk;
    logic        rst;
    nx_word_t    in_data;
    logic        in_last;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] out_data;
    logic        out_last;
    logic        out_valid;
    logic        out_ready;

    logic        random_ready;
    logic [31:0] ready_rnd;
    int          value_errors;
    int          other_errors;

    // Words of the message that send_msg drives next
    nx_word_t    msg_buf [$];
    // Expected forwarded words and expected response words, each in order
    nx_word_t    fwd_data [$];
    logic        fwd_last [$];
    nx_word_t    rsp_data [$];
    logic        rsp_last [$];
    nx_opcode_e  rsp_op [$];
    // Words seen on the outbound stream
    nx_word_t    out_data_q [$];
    logic        out_last_q [$];
    // Register file as the tests expect it
    nx_word_t    reg_model [NX_NUM_REGS];

    tb_clock clk0 (
        .clk(clk),
        .rst(rst)
    );

    nx_node #(.NODE_ID(NODE_ID), .BUS_W(32)) dut0 (
        .clk, .rst,
        .in_data, .in_last, .in_valid, .in_ready,
        .out_data, .out_last, .out_valid, .out_ready
    );

    // Outbound ready, either always high or a coin flip per cycle
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #(DRIVE_DELAY);
            if (random_ready) begin
                ready_rnd = $urandom;
                out_ready = ready_rnd[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Outbound words are taken at the falling edge, where both sides are settled
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && out_valid && out_ready) begin
                out_data_q.push_back(out_data);
                out_last_q.push_back(out_last);
            end
        end
    end

    // The whole run gets 200 cycles per test
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run is hung", NUM_TESTS * 200);
        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("Errors found");
        $finish;
    end

    task automatic check_data(input string name, input nx_word_t got, input nx_word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_opcode(input string name, input nx_opcode_e got,
                                input nx_opcode_e exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic nx_word_t make_header(input nx_node_t node, input nx_opcode_e op,
                                             input nx_reg_idx_t idx);
        nx_word_t h;
        h = '0;
        h[HDR_NODE_LSB +: 4] = node;
        h[HDR_OP_LSB +: 2]   = op;
        h[HDR_REG_LSB +: 4]  = idx;
        return h;
    endfunction

    // Any node from 1 to 15 except our own
    function automatic nx_node_t pick_node();
        logic [31:0] r;
        nx_node_t    n;
        r = $urandom;
        n = nx_node_t'(r % 14) + 4'd1;
        if (n >= NODE_ID) begin
            n = n + 4'd1;
        end
        return n;
    endfunction

    // Called 1 ns after an edge and returns 1 ns after the edge that takes the last word
    task automatic send_msg();
        int n;
        n = msg_buf.size();
        for (int i = 0; i < n; i++) begin
            in_data  = msg_buf[i];
            in_last  = (i == n - 1);
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    // A response is the opcode and register index, then the value with last
    task automatic expect_response(input nx_opcode_e op, input nx_reg_idx_t idx,
                                   input nx_word_t value);
        rsp_data.push_back(make_header(4'd0, op, idx));
        rsp_last.push_back(1'b0);
        rsp_data.push_back(value);
        rsp_last.push_back(1'b1);
        rsp_op.push_back(op);
    endtask

    task automatic do_write(input nx_reg_idx_t idx, input nx_word_t value);
        msg_buf.delete();
        msg_buf.push_back(make_header(NODE_ID, OP_WRITE, idx));
        msg_buf.push_back(value);
        send_msg();
        reg_model[idx] = value;
    endtask

    task automatic do_read(input nx_reg_idx_t idx);
        msg_buf.delete();
        msg_buf.push_back(make_header(NODE_ID, OP_READ, idx));
        send_msg();
        expect_response(OP_READ, idx, reg_model[idx]);
    endtask

    task automatic do_add(input nx_reg_idx_t idx, input nx_word_t addend);
        msg_buf.delete();
        msg_buf.push_back(make_header(NODE_ID, OP_ADD, idx));
        msg_buf.push_back(addend);
        send_msg();
        // The sum wraps modulo 2^32
        reg_model[idx] = reg_model[idx] + addend;
        expect_response(OP_ADD, idx, reg_model[idx]);
    endtask

    task automatic do_reserved(input nx_reg_idx_t idx);
        msg_buf.delete();
        msg_buf.push_back(make_header(NODE_ID, OP_RSVD, idx));
        send_msg();
    endtask

    task automatic do_forward(input nx_node_t node, input int nwords);
        nx_word_t w;
        msg_buf.delete();
        for (int i = 0; i < nwords; i++) begin
            w = $urandom;
            if (i == 0) begin
                w[HDR_NODE_LSB +: 4] = node;
            end
            msg_buf.push_back(w);
            fwd_data.push_back(w);
            fwd_last.push_back(i == nwords - 1);
        end
        send_msg();
    endtask

    // Waits for all expected words, then splits the outbound words into runs up to last
    // The first word of a run tells a response from a forwarded message
    task automatic drain_and_check();
        int       expected;
        int       waited;
        nx_word_t w;
        logic     l;
        logic     from_rsp;
        logic     in_msg;
        expected = fwd_data.size() + rsp_data.size();
        waited   = 0;
        while (out_data_q.size() < expected && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        // A few more cycles so that stray extra words show up too
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        if (out_data_q.size() < expected) begin
            other_errors++;
            $display("Missing outbound words: expected %0d but only %0d arrived",
                     expected, out_data_q.size());
        end
        in_msg   = 1'b0;
        from_rsp = 1'b0;
        while (out_data_q.size() > 0) begin
            w = out_data_q.pop_front();
            l = out_last_q.pop_front();
            if (!in_msg) begin
                from_rsp = (w[HDR_NODE_LSB +: 4] == 4'd0);
                if (from_rsp && rsp_op.size() > 0) begin
                    check_opcode("out_data opcode", nx_opcode_e'(w[HDR_OP_LSB +: 2]),
                                 rsp_op.pop_front());
                end
            end
            if (from_rsp && rsp_data.size() > 0) begin
                check_data("out_data", w, rsp_data.pop_front());
                check_last("out_last", l, rsp_last.pop_front());
            end else if (!from_rsp && fwd_data.size() > 0) begin
                check_data("out_data", w, fwd_data.pop_front());
                check_last("out_last", l, fwd_last.pop_front());
            end else begin
                other_errors++;
                $display("Unexpected outbound word %h that matches no pending message", w);
            end
            in_msg = !l;
        end
        if (in_msg) begin
            other_errors++;
            $display("Outbound stream stopped in the middle of a message");
        end
        fwd_data.delete();
        fwd_last.delete();
        rsp_data.delete();
        rsp_last.delete();
        rsp_op.delete();
    endtask

    task automatic test_reset();
        @(negedge clk);
        while (rst) begin
            if (out_valid !== 1'b0) begin
                other_errors++;
                $display("Outbound valid was high during reset");
            end
            @(negedge clk);
        end
        // Decode takes one cycle to leave reset
        if (in_ready !== 1'b0) begin
            other_errors++;
            $display("Inbound ready was high in the first cycle after reset");
        end
        repeat (3) begin
            if (out_valid !== 1'b0) begin
                other_errors++;
                $display("Outbound valid was high just after reset with no input");
            end
            @(negedge clk);
        end
        if (out_data_q.size() != 0) begin
            other_errors++;
            $display("Outbound words appeared around reset");
        end
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic test_write_read();
        nx_word_t v;
        for (int i = 0; i < 6; i++) begin
            v = $urandom;
            do_write(nx_reg_idx_t'(i * 3), v);
        end
        for (int i = 0; i < 6; i++) begin
            do_read(nx_reg_idx_t'(i * 3));
        end
        drain_and_check();
    endtask

    task automatic test_add();
        nx_word_t v;
        nx_word_t a;
        v = $urandom;
        a = $urandom;
        do_write(4'd7, v);
        do_add(4'd7, a);
        do_read(4'd7);
        // This one crosses 2^32 and wraps
        do_write(4'd2, 32'hFFFF_FFF0);
        do_add(4'd2, 32'h0000_0025);
        do_read(4'd2);
        do_add(4'd2, a);
        drain_and_check();
    endtask

    task automatic test_forward();
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            r = $urandom;
            do_forward(pick_node(), 1 + int'(r[1:0]));
        end
        // Reserved opcode to us is swallowed, later traffic runs on as normal
        do_reserved(4'd9);
        do_read(4'd9);
        do_forward(pick_node(), 3);
        drain_and_check();
    endtask

    task automatic test_merge();
        logic [31:0] r;
        random_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            r = $urandom;
            if (r[0]) begin
                do_forward(pick_node(), 1 + int'(r[2:1]));
            end else begin
                do_read(r[7:4]);
            end
        end
        drain_and_check();
        random_ready = 1'b0;
    endtask

    initial begin
        in_data      = '0;
        in_last      = 1'b0;
        in_valid     = 1'b0;
        random_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));
        for (int i = 0; i < NX_NUM_REGS; i++) begin
            reg_model[i] = '0;
        end

        test_reset();
        test_write_read();
        test_add();
        test_forward();
        test_merge();

        $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
nx_pkg.sv
nx_arbiter.sv
nx_decode.sv
nx_execute.sv
nx_result.sv
nx_node.sv
tb_clock.sv
tb_nx_node.sv
